/* filelist.f */
design/dcache_pkg.sv
design/dcache_rd_ctrl.sv
design/dcache_mem.sv
design/dcache_miss_unit.sv
design/dcache_top.sv
sim/tb_clk_gen.sv
sim/tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_dcache.sv */
module tb_dcache;
  timeunit 1ns;
  timeprecision 1ps;
  import dcache_pkg::*;

  localparam int NUM_RAND = 200;
  // worst case line miss is about 33 cycles, plus the directed tests
  localparam int MAX_CYC  = NUM_RAND * 33 + 1200;

  typedef struct packed {
    logic [PLEN-1:0] addr;
    logic [ID_W-1:0] id;
  } exp_t;

  logic              clk, rst_n, cache_en, mem_req, mem_rvalid;
  logic [WORD_W-1:0] mem_rdata;
  dcache_req_t       core_req;
  dcache_rsp_t       core_rsp;
  mem_req_t          mem_o;

  int     seed = 77250;
  int     cyc, fetch_cnt, exp_fetch;
  string  cur_test;
  exp_t   exp_q[$];
  exp_t   pend;
  logic   pend_vld;
  // reference model of tags, valid bits and replacement bits
  logic [TAG_W-1:0]    m_tag [16][2];
  logic [NUM_WAYS-1:0] m_vld [16];
  logic                m_repl [16];
  logic [TAG_W-1:0]    tag_pool [4] = '{8'h01, 8'h02, 8'h03, 8'h81};

  tb_clk_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  dcache_top u_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .cache_en_i   (cache_en),
    .req_port_i   (core_req),
    .req_port_o   (core_rsp),
    .mem_req_o    (mem_req),
    .mem_o        (mem_o),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  //////////////////////////////////////////////////
  // helpers and reference model
  //////////////////////////////////////////////////

  // memory content of a word address
  function automatic logic [WORD_W-1:0] mem_word(input logic [13:0] w);
    return ({18'd0, w} * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("FAILED %s %s expected %h actual %h", cur_test, what, exp_v, act_v);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("%s: %s", cur_test, msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // returns 1 when the read must fetch from memory, updates the model
  function automatic bit predict_fetch(input logic [PLEN-1:0] addr);
    logic [3:0]       s;
    logic [TAG_W-1:0] t;
    logic             v;
    s = addr[7:4];
    t = addr[15:8];
    exp_fetch++;
    // uncached region or disabled cache
    if (!cache_en || addr[15]) return 1'b1;
    for (int w = 0; w < 2; w++) begin
      if (m_vld[s][w] && m_tag[s][w] == t) begin
        exp_fetch--;
        return 1'b0;
      end
    end
    if (!m_vld[s][0]) v = 1'b0;
    else if (!m_vld[s][1]) v = 1'b1;
    else begin
      v = m_repl[s];
      m_repl[s] = ~m_repl[s];
    end
    m_vld[s][v] = 1'b1;
    m_tag[s][v] = t;
    return 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // core port driver
  //////////////////////////////////////////////////

  // wait for grant, the tag and kill strobes last one cycle
  task automatic wait_gnt();
    @(negedge clk);
    while (!core_rsp.gnt) begin
      @(posedge clk);
      core_req.tag_valid <= 1'b0;
      core_req.kill      <= 1'b0;
      @(negedge clk);
    end
  endtask

  // new request, sent together with the tag of the pending one
  task automatic start(input logic [PLEN-1:0] addr, input logic [ID_W-1:0] id);
    exp_t e;
    @(posedge clk);
    if (pend_vld) begin
      core_req.tag_valid <= 1'b1;
      core_req.tag       <= pend.addr[15:8];
      void'(predict_fetch(pend.addr));
    end
    core_req.req   <= 1'b1;
    core_req.index <= addr[7:0];
    core_req.id    <= id;
    wait_gnt();
    e.addr = addr;
    e.id   = id;
    exp_q.push_back(e);
    pend     = e;
    pend_vld = 1'b1;
  endtask

  // mode 0 tag, mode 1 kill after grant, mode 2 kill during the miss
  task automatic finish(input int mode);
    bit fetch;
    @(posedge clk);
    core_req.req       <= 1'b0;
    core_req.kill      <= (mode == 1);
    core_req.tag_valid <= (mode != 1);
    core_req.tag       <= pend.addr[15:8];
    fetch    = (mode != 1) ? predict_fetch(pend.addr) : 1'b0;
    pend_vld = 1'b0;
    @(negedge clk);
    if (mode == 0 && !fetch) begin
      assert (core_rsp.rvalid) else report_error("hit gave no rvalid with tag_valid");
    end
    @(posedge clk);
    core_req.tag_valid <= 1'b0;
    core_req.kill      <= 1'b0;
    if (mode == 2) begin
      @(posedge clk);
      @(posedge clk);
      core_req.kill <= 1'b1;
      @(posedge clk);
      core_req.kill <= 1'b0;
    end
    while (exp_q.size() != 0) @(negedge clk);
    assert (fetch_cnt == exp_fetch)
      else report_mismatch("fetch count", 32'(exp_fetch), 32'(fetch_cnt));
  endtask

  //////////////////////////////////////////////////
  // memory model and monitors
  //////////////////////////////////////////////////

  initial begin : mem_model
    logic [13:0] base;
    int          n;
    int          d;
    forever begin
      @(negedge clk);
      if (rst_n && mem_req) begin
        base = mem_o.addr[15:2];
        n    = mem_o.nc ? 1 : 4;
        for (int k = 0; k < n; k++) begin
          // 1 to 6 cycles before each word
          d = 1 + ({$random(seed)} % 6);
          repeat (d) @(posedge clk);
          mem_rvalid <= 1'b1;
          mem_rdata  <= mem_word(base + 14'(k));
          @(posedge clk);
          mem_rvalid <= 1'b0;
        end
      end
    end
  end

  always @(negedge clk) begin : rsp_check
    exp_t e;
    logic nc_exp;
    if (rst_n) begin
      if (mem_req) begin
        fetch_cnt++;
        assert (exp_q.size() != 0) else report_error("memory fetch with no request in flight");
        // single word fetch only for I/O or with the cache off
        e      = exp_q[0];
        nc_exp = !cache_en || e.addr[15];
        assert (mem_o.nc == nc_exp)
          else report_mismatch("fetch nc", 32'(nc_exp), 32'(mem_o.nc));
      end
      if (core_rsp.rvalid) begin
        assert (exp_q.size() != 0) else report_error("rvalid with no request in flight");
        e = exp_q.pop_front();
        assert (core_rsp.rid == e.id)
          else report_mismatch("rid", 32'(e.id), 32'(core_rsp.rid));
        // killed responses carry no data
        if (!core_req.kill) begin
          assert (core_rsp.rdata == mem_word(e.addr[15:2]))
            else report_mismatch("rdata", mem_word(e.addr[15:2]), core_rsp.rdata);
        end
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == MAX_CYC) begin
      $display("timeout after %0d cycles in %s", cyc, cur_test);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    core_req   = '0;
    cache_en   = 1'b1;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    cyc        = 0;
    fetch_cnt  = 0;
    exp_fetch  = 0;
    pend_vld   = 1'b0;
    pend       = '0;
    cur_test   = "reset";
    for (int s = 0; s < 16; s++) begin
      m_vld[s]  = '0;
      m_repl[s] = 1'b0;
    end
    @(posedge rst_n);

    cur_test = "cold_line";
    start(16'h0120, 2'd0); finish(0);
    cur_test = "same_line_hit";
    start(16'h0128, 2'd1); finish(0);

    cur_test = "io_region";
    start(16'h8130, 2'd2); finish(0);
    start(16'h8130, 2'd3); finish(0);
    cur_test = "cache_disabled";
    @(posedge clk);
    cache_en <= 1'b0;
    start(16'h0124, 2'd0); finish(0);
    start(16'h0124, 2'd1); finish(0);
    @(posedge clk);
    cache_en <= 1'b1;

    // three tags on set 5 push the first one out
    cur_test = "eviction";
    start(16'h1050, 2'd0); finish(0);
    start(16'h1150, 2'd1); finish(0);
    start(16'h1250, 2'd2); finish(0);
    start(16'h1054, 2'd3); finish(0);
    start(16'h1258, 2'd0); finish(0);

    cur_test = "kill_after_grant";
    start(16'h0134, 2'd1); finish(1);
    start(16'h0120, 2'd2); finish(0);
    cur_test = "kill_during_miss";
    start(16'h3360, 2'd3); finish(2);
    start(16'h3364, 2'd0); finish(0);

    // back to back stream over two sets and four tags
    cur_test = "random";
    for (int i = 0; i < NUM_RAND; i++) begin
      r = $random(seed);
      start({tag_pool[r[1:0]], 3'b000, r[2], r[4:3], 2'b00}, 2'(i));
    end
    finish(0);

    $display("TB PASSED");
    $finish;
  end

endmodule

/* sim/tb_clk_gen.sv */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset held low for the first 4 cycles
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* design/dcache_top.sv */
module dcache_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              cache_en_i,
  // core read port
  input  dcache_pkg::dcache_req_t           req_port_i,
  output dcache_pkg::dcache_rsp_t           req_port_o,
  // word memory
  output logic                              mem_req_o,
  output dcache_pkg::mem_req_t              mem_o,
  input  logic                              mem_rvalid_i,
  input  logic [dcache_pkg::WORD_W-1:0]     mem_rdata_i
);
  import dcache_pkg::*;

  // controller to miss unit
  logic                miss_req, miss_ack, miss_rtrn_vld;
  miss_req_t           miss;
  logic [WORD_W-1:0]   miss_rtrn_data;
  // controller to arrays
  logic                rd_req, rd_ack, wr_cl_vld;
  logic [IDX_W-1:0]    rd_idx;
  logic [OFF_W-1:0]    rd_off;
  logic [TAG_W-1:0]    rd_tag;
  logic [WORD_W-1:0]   rd_data;
  logic [NUM_WAYS-1:0] rd_vld_bits, rd_hit_oh;
  // miss unit to arrays
  logic                refill_vld;
  refill_t             refill;

  dcache_rd_ctrl u_ctrl (
    .clk_i, .rst_ni, .cache_en_i, .req_port_i, .req_port_o,
    .miss_req_o       (miss_req),
    .miss_o           (miss),
    .miss_ack_i       (miss_ack),
    .miss_rtrn_vld_i  (miss_rtrn_vld),
    .miss_rtrn_data_i (miss_rtrn_data),
    .wr_cl_vld_i      (wr_cl_vld),
    .rd_req_o         (rd_req),
    .rd_idx_o         (rd_idx),
    .rd_off_o         (rd_off),
    .rd_tag_o         (rd_tag),
    .rd_ack_i         (rd_ack),
    .rd_data_i        (rd_data),
    .rd_vld_bits_i    (rd_vld_bits),
    .rd_hit_oh_i      (rd_hit_oh)
  );

  dcache_mem u_mem (
    .clk_i, .rst_ni,
    .rd_req_i      (rd_req),
    .rd_idx_i      (rd_idx),
    .rd_off_i      (rd_off),
    .rd_tag_i      (rd_tag),
    .rd_ack_o      (rd_ack),
    .rd_data_o     (rd_data),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_hit_oh_o   (rd_hit_oh),
    .refill_vld_i  (refill_vld),
    .refill_i      (refill),
    .wr_cl_vld_o   (wr_cl_vld)
  );

  dcache_miss_unit u_miss (
    .clk_i, .rst_ni,
    .miss_req_i       (miss_req),
    .miss_i           (miss),
    .miss_ack_o       (miss_ack),
    .miss_rtrn_vld_o  (miss_rtrn_vld),
    .miss_rtrn_data_o (miss_rtrn_data),
    .refill_vld_o     (refill_vld),
    .refill_o         (refill),
    .mem_req_o, .mem_o, .mem_rvalid_i, .mem_rdata_i
  );

endmodule

/* design/dcache_miss_unit.sv */
module dcache_miss_unit (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // controller side
  input  logic                              miss_req_i,
  input  dcache_pkg::miss_req_t             miss_i,
  output logic                              miss_ack_o,
  output logic                              miss_rtrn_vld_o,
  output logic [dcache_pkg::WORD_W-1:0]     miss_rtrn_data_o,
  // refill into the arrays
  output logic                              refill_vld_o,
  output dcache_pkg::refill_t               refill_o,
  // word memory
  output logic                              mem_req_o,
  output dcache_pkg::mem_req_t              mem_o,
  input  logic                              mem_rvalid_i,
  input  logic [dcache_pkg::WORD_W-1:0]     mem_rdata_i
);
  import dcache_pkg::*;

  typedef enum logic {MU_IDLE, MU_FETCH} mu_state_e;

  mu_state_e state_q;
  logic [WOFF_W-1:0]                     cnt_q;
  logic [PLEN-1:0]                       paddr_q;
  logic                                  nc_q;
  logic [NUM_WAYS-1:0]                   vld_bits_q;
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_q, line_d;
  // one replacement bit per set
  logic [2**IDX_W-1:0]                   repl_q;
  logic                                  last_word, all_vld;
  logic [IDX_W-1:0]                      set_idx;

  // accept only while idle, fetch goes out in the same cycle
  assign miss_ack_o = miss_req_i && (state_q == MU_IDLE);
  assign mem_req_o  = miss_ack_o;
  // nc fetches one word, cacheable fetches start at the line base
  assign mem_o.addr = miss_i.nc ? {miss_i.paddr[PLEN-1:2], 2'b00}
                                : {miss_i.paddr[PLEN-1:OFF_W], {OFF_W{1'b0}}};
  assign mem_o.nc   = miss_i.nc;

  // line buffer with the word arriving this cycle merged in
  always_comb begin
    line_d        = line_q;
    line_d[cnt_q] = mem_rdata_i;
  end

  assign last_word       = nc_q || (cnt_q == WOFF_W'(WORDS_PER_LINE - 1));
  assign miss_rtrn_vld_o = (state_q == MU_FETCH) && mem_rvalid_i && last_word;
  assign miss_rtrn_data_o = nc_q ? mem_rdata_i : line_d[paddr_q[OFF_W-1 -: WOFF_W]];
  assign refill_vld_o    = miss_rtrn_vld_o && !nc_q;

  // victim is the first invalid way, else the set's replacement way
  assign set_idx = paddr_q[OFF_W +: IDX_W];
  assign all_vld = &vld_bits_q;
  always_comb begin
    refill_o.way = '0;
    refill_o.way[repl_q[set_idx]] = 1'b1;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!vld_bits_q[w]) begin
        refill_o.way    = '0;
        refill_o.way[w] = 1'b1;
      end
    end
  end
  assign refill_o.idx  = set_idx;
  assign refill_o.tag  = paddr_q[PLEN-1 -: TAG_W];
  assign refill_o.data = line_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MU_IDLE;
      cnt_q   <= '0;
      repl_q  <= '0;
    end else begin
      if (miss_ack_o) begin
        state_q <= MU_FETCH;
        cnt_q   <= '0;
      end else if (state_q == MU_FETCH && mem_rvalid_i) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_word) begin
          state_q <= MU_IDLE;
        end
      end
      // flip only when a valid line was evicted
      if (refill_vld_o && all_vld) begin
        repl_q[set_idx] <= ~repl_q[set_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_ack_o) begin
      paddr_q    <= miss_i.paddr;
      nc_q       <= miss_i.nc;
      vld_bits_q <= miss_i.vld_bits;
    end
    if (state_q == MU_FETCH && mem_rvalid_i) begin
      line_q <= line_d;
    end
  end

endmodule

/* design/dcache_mem.sv */
module dcache_mem (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // read port
  input  logic                              rd_req_i,
  input  logic [dcache_pkg::IDX_W-1:0]      rd_idx_i,
  input  logic [dcache_pkg::OFF_W-1:0]      rd_off_i,
  // late tag, valid in the cycle after the read
  input  logic [dcache_pkg::TAG_W-1:0]      rd_tag_i,
  output logic                              rd_ack_o,
  output logic [dcache_pkg::WORD_W-1:0]     rd_data_o,
  output logic [dcache_pkg::NUM_WAYS-1:0]   rd_vld_bits_o,
  output logic [dcache_pkg::NUM_WAYS-1:0]   rd_hit_oh_o,
  // refill write port
  input  logic                              refill_vld_i,
  input  dcache_pkg::refill_t               refill_i,
  output logic                              wr_cl_vld_o
);
  import dcache_pkg::*;

  localparam int NUM_SETS = 2 ** IDX_W;

  // storage, valid bits per set hold all ways
  logic [NUM_WAYS-1:0]                   vld_mem [NUM_SETS];
  logic [TAG_W-1:0]                      tag_mem [NUM_WAYS][NUM_SETS];
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] data_mem [NUM_WAYS][NUM_SETS];

  // registered readout of all ways
  logic [NUM_WAYS-1:0] vld_rd_q;
  logic [TAG_W-1:0]    tag_rd_q [NUM_WAYS];
  logic [WORD_W-1:0]   data_rd_q [NUM_WAYS];

  // refill owns the arrays for its cycle
  assign rd_ack_o    = rd_req_i & ~refill_vld_i;
  assign wr_cl_vld_o = refill_vld_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_mem  <= '{default: '0};
      vld_rd_q <= '0;
    end else begin
      if (refill_vld_i) begin
        vld_mem[refill_i.idx] <= vld_mem[refill_i.idx] | refill_i.way;
      end
      if (rd_ack_o) begin
        vld_rd_q <= vld_mem[rd_idx_i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (refill_vld_i && refill_i.way[w]) begin
        tag_mem[w][refill_i.idx]  <= refill_i.tag;
        data_mem[w][refill_i.idx] <= refill_i.data;
      end
      // only the addressed word leaves the array
      if (rd_ack_o) begin
        tag_rd_q[w]  <= tag_mem[w][rd_idx_i];
        data_rd_q[w] <= data_mem[w][rd_idx_i][rd_off_i[OFF_W-1 -: WOFF_W]];
      end
    end
  end

  assign rd_vld_bits_o = vld_rd_q;

  // tag compare and one-hot data select
  always_comb begin
    rd_data_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_hit_oh_o[w] = vld_rd_q[w] && (tag_rd_q[w] == rd_tag_i);
      if (rd_hit_oh_o[w]) begin
        rd_data_o = rd_data_o | data_rd_q[w];
      end
    end
  end

endmodule

/* design/dcache_rd_ctrl.sv */
module dcache_rd_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              cache_en_i,
  // core read port
  input  dcache_pkg::dcache_req_t           req_port_i,
  output dcache_pkg::dcache_rsp_t           req_port_o,
  // miss unit
  output logic                              miss_req_o,
  output dcache_pkg::miss_req_t             miss_o,
  input  logic                              miss_ack_i,
  input  logic                              miss_rtrn_vld_i,
  input  logic [dcache_pkg::WORD_W-1:0]     miss_rtrn_data_i,
  // high while a refill is written
  input  logic                              wr_cl_vld_i,
  // arrays
  output logic                              rd_req_o,
  output logic [dcache_pkg::IDX_W-1:0]      rd_idx_o,
  output logic [dcache_pkg::OFF_W-1:0]      rd_off_o,
  output logic [dcache_pkg::TAG_W-1:0]      rd_tag_o,
  input  logic                              rd_ack_i,
  input  logic [dcache_pkg::WORD_W-1:0]     rd_data_i,
  input  logic [dcache_pkg::NUM_WAYS-1:0]   rd_vld_bits_i,
  input  logic [dcache_pkg::NUM_WAYS-1:0]   rd_hit_oh_i
);
  import dcache_pkg::*;

  ctrl_state_e state_d, state_q;

  logic [TAG_W-1:0]    tag_d, tag_q;
  logic [IDX_W-1:0]    idx_d, idx_q;
  logic [OFF_W-1:0]    off_d, off_q;
  logic [ID_W-1:0]     id_d, id_q;
  logic [NUM_WAYS-1:0] vld_d, vld_q;
  logic                rd_ack_q;
  logic                save_tag, gnt, rvalid;
  logic [PLEN-1:0]     cmp_paddr;
  logic                cmp_nc;

  //////////////////////////////////////////////////
  // address capture
  //////////////////////////////////////////////////

  // index, offset and id latch on grant, tag one cycle later
  assign idx_d = gnt ? req_port_i.index[IDX_W+OFF_W-1:OFF_W] : idx_q;
  assign off_d = gnt ? req_port_i.index[OFF_W-1:0] : off_q;
  assign id_d  = gnt ? req_port_i.id : id_q;
  assign tag_d = save_tag ? req_port_i.tag : tag_q;
  // valid bits of the last acknowledged readout, for victim choice
  assign vld_d = rd_ack_q ? rd_vld_bits_i : vld_q;

  // read address follows the next values so a new grant reads at once
  assign rd_idx_o = idx_d;
  assign rd_off_o = off_d;
  assign rd_tag_o = tag_d;

  // full address seen in the compare cycle
  assign cmp_paddr = {tag_d, idx_q, off_q};
  // disabled cache or I/O address never hits
  assign cmp_nc    = ~cache_en_i | is_io_addr(cmp_paddr);

  assign miss_o.paddr    = {tag_q, idx_q, off_q};
  assign miss_o.nc       = ~cache_en_i | is_io_addr(miss_o.paddr);
  assign miss_o.vld_bits = vld_q;

  assign req_port_o.gnt    = gnt;
  assign req_port_o.rvalid = rvalid;
  // miss return data only while waiting on the miss unit
  assign req_port_o.rdata  = (state_q == MISS_WAIT) ? miss_rtrn_data_i : rd_data_i;
  assign req_port_o.rid    = id_q;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    save_tag   = 1'b0;
    rd_req_o   = 1'b0;
    miss_req_o = 1'b0;
    rvalid     = 1'b0;
    gnt        = 1'b0;

    unique case (state_q)
      // grant as soon as the arrays take the read
      IDLE: begin
        if (req_port_i.req) begin
          rd_req_o = 1'b1;
          if (rd_ack_i) begin
            gnt     = 1'b1;
            state_d = READ;
          end
        end
      end
      // compare cycle, keep reading for a possible next request
      READ, REPLAY_READ: begin
        rd_req_o = 1'b1;
        if (req_port_i.kill) begin
          rvalid  = 1'b1;
          state_d = IDLE;
        end else if (req_port_i.tag_valid || state_q == REPLAY_READ) begin
          save_tag = (state_q == READ);
          if (wr_cl_vld_i || !rd_ack_q) begin
            // readout collided with a refill
            state_d = REPLAY_REQ;
          end else if ((|rd_hit_oh_i) && !cmp_nc) begin
            rvalid  = 1'b1;
            state_d = IDLE;
            // hit under a back-to-back grant
            if (req_port_i.req && rd_ack_i) begin
              gnt     = 1'b1;
              state_d = READ;
            end
          end else begin
            state_d = MISS_REQ;
          end
        end
      end
      // hold the miss request until acknowledged
      MISS_REQ: begin
        miss_req_o = 1'b1;
        if (req_port_i.kill) begin
          rvalid  = 1'b1;
          state_d = miss_ack_i ? KILL_MISS : KILL_MISS_ACK;
        end else if (miss_ack_i) begin
          state_d = MISS_WAIT;
        end
      end
      MISS_WAIT: begin
        if (req_port_i.kill) begin
          rvalid  = 1'b1;
          state_d = miss_rtrn_vld_i ? IDLE : KILL_MISS;
        end else if (miss_rtrn_vld_i) begin
          rvalid  = 1'b1;
          state_d = IDLE;
        end
      end
      REPLAY_REQ: begin
        rd_req_o = 1'b1;
        if (req_port_i.kill) begin
          rvalid  = 1'b1;
          state_d = IDLE;
        end else if (rd_ack_i) begin
          state_d = REPLAY_READ;
        end
      end
      // killed before ack, the miss still has to be handed over
      KILL_MISS_ACK: begin
        miss_req_o = 1'b1;
        if (miss_ack_i) begin
          state_d = KILL_MISS;
        end
      end
      // drain the killed fetch
      KILL_MISS: begin
        if (miss_rtrn_vld_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      rd_ack_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rd_ack_q <= rd_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin
    tag_q <= tag_d;
    idx_q <= idx_d;
    off_q <= off_d;
    id_q  <= id_d;
    vld_q <= vld_d;
  end

endmodule

/* design/dcache_pkg.sv */
package dcache_pkg;

  // address and data geometry
  localparam int PLEN           = 16;
  localparam int WORD_W         = 32;
  localparam int OFF_W          = 4;
  localparam int IDX_W          = 4;
  localparam int TAG_W          = 8;
  localparam int NUM_WAYS       = 2;
  localparam int WORDS_PER_LINE = 4;
  // word select bits inside the byte offset
  localparam int WOFF_W         = 2;
  localparam int ID_W           = 2;
  // top address bit selects the I/O region
  localparam int IO_BIT         = 15;

  // core to cache, index and offset travel together
  typedef struct packed {
    logic                     req;
    logic [IDX_W+OFF_W-1:0]   index;
    logic [ID_W-1:0]          id;
    logic                     kill;
    logic                     tag_valid;
    logic [TAG_W-1:0]         tag;
  } dcache_req_t;

  // cache to core
  typedef struct packed {
    logic                     gnt;
    logic                     rvalid;
    logic [WORD_W-1:0]        rdata;
    logic [ID_W-1:0]          rid;
  } dcache_rsp_t;

  // controller to miss unit
  typedef struct packed {
    logic [PLEN-1:0]          paddr;
    logic                     nc;
    logic [NUM_WAYS-1:0]      vld_bits;
  } miss_req_t;

  // miss unit to word memory
  typedef struct packed {
    logic [PLEN-1:0]          addr;
    logic                     nc;
  } mem_req_t;

  // refill write into the arrays
  typedef struct packed {
    logic [NUM_WAYS-1:0]                        way;
    logic [IDX_W-1:0]                           idx;
    logic [TAG_W-1:0]                           tag;
    logic [WORDS_PER_LINE-1:0][WORD_W-1:0]      data;
  } refill_t;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    MISS_REQ,
    MISS_WAIT,
    KILL_MISS,
    KILL_MISS_ACK,
    REPLAY_REQ,
    REPLAY_READ
  } ctrl_state_e;

  // I/O space is never cached
  function automatic logic is_io_addr(input logic [PLEN-1:0] addr);
    return addr[IO_BIT];
  endfunction

endpackage
